// ==== Bender.yml ====
package:
  name: spmm

sources:
  - spmm_pkg.sv
  - node_info_fifo.sv
  - row_sequencer.sv
  - sparse_pe.sv
  - wh_writer.sv
  - spmm_top.sv
  - target: simulation
    files:
      - spmm_checker.sv
      - tb_spmm.sv

// ==== node_info_fifo.sv ====
// Push is ignored when full and pop when empty; the head word is valid only while not empty
`default_nettype none
`timescale 1ns/1ps

module node_info_fifo #(
  parameter int DEPTH = spmm_pkg::FIFO_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push_i,
  input  spmm_pkg::node_info_t push_data_i,
  input  logic                 pop_i,
  output spmm_pkg::node_info_t head_o,
  output logic                 empty_o,
  output logic                 full_o
);
  import spmm_pkg::*;

  node_info_t                  mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]    wr_ptr;
  logic [$clog2(DEPTH)-1:0]    rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]  count;
  logic                        do_push;
  logic                        do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (count == '0);
  assign full_o  = (count == DEPTH);
  assign head_o  = mem[rd_ptr];

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== row_sequencer.sv ====
// Every row must hold at least one nonzero, and start_i must stay high until the run is done
`default_nettype none
`timescale 1ns/1ps

module row_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  output spmm_pkg::node_addr_t node_addr_o,
  input  spmm_pkg::node_info_t node_dout_i,
  output spmm_pkg::h_addr_t    h_addr_o,
  input  spmm_pkg::h_entry_t   h_dout_i,
  output spmm_pkg::pe_elem_t   elem_o
);
  import spmm_pkg::*;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DONE
  } seq_state_e;

  seq_state_e            state_q;
  seq_state_e            state_d;
  logic                  running;

  // Node-info fetch
  node_addr_t            node_addr_q;
  logic [ROW_CNT_W-1:0]  fetch_cnt_q;
  logic [FIFO_CNT_W-1:0] credit_q;
  logic                  node_rd;
  logic                  node_rd_q;

  // Prefetch queue
  logic                  fifo_push;
  logic                  fifo_pop;
  node_info_t            head;
  logic                  fifo_empty;
  logic                  fifo_full;

  // Entry walk
  h_addr_t               h_addr_q;
  row_len_t              ent_cnt_q;
  logic [ROW_CNT_W-1:0]  rows_done_q;
  logic                  issue;
  logic                  last;

  // Control that lines up with returning H data
  logic                  vld_q;
  logic                  last_q;
  num_node_t             num_node_q;
  logic                  src_flag_q;

  assign running   = (state_q == SEQ_RUN);
  // Slots held by queued words plus the read still in flight
  assign node_rd   = running && (fetch_cnt_q < NUM_ROWS) && (credit_q < FIFO_DEPTH);
  assign fifo_push = node_rd_q && !fifo_full;
  assign issue     = running && !fifo_empty;
  assign last      = (ent_cnt_q == head.row_len - 1'b1);
  assign fifo_pop  = issue && last;

  assign node_addr_o = node_addr_q;
  assign h_addr_o    = h_addr_q;

  node_info_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (fifo_push),
    .push_data_i (node_dout_i),
    .pop_i       (fifo_pop),
    .head_o      (head),
    .empty_o     (fifo_empty),
    .full_o      (fifo_full)
  );

  // ====================
  // Run control
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (start_i) begin
          state_d = SEQ_RUN;
        end
      end
      SEQ_RUN: begin
        if (fifo_pop && rows_done_q == ROW_CNT_W'(NUM_ROWS - 1)) begin
          state_d = SEQ_DONE;
        end
      end
      SEQ_DONE: begin
        if (!start_i) begin
          state_d = SEQ_IDLE;
        end
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= SEQ_IDLE;
      node_rd_q   <= 1'b0;
      node_addr_q <= '0;
      fetch_cnt_q <= '0;
      credit_q    <= '0;
      h_addr_q    <= '0;
      ent_cnt_q   <= '0;
      rows_done_q <= '0;
    end else begin
      state_q   <= state_d;
      node_rd_q <= node_rd;
      if (state_q == SEQ_IDLE) begin
        node_addr_q <= '0;
        fetch_cnt_q <= '0;
        credit_q    <= '0;
        h_addr_q    <= '0;
        ent_cnt_q   <= '0;
        rows_done_q <= '0;
      end else begin
        if (node_rd) begin
          node_addr_q <= node_addr_q + 1'b1;
          fetch_cnt_q <= fetch_cnt_q + 1'b1;
        end
        case ({node_rd, fifo_pop})
          2'b10:   credit_q <= credit_q + 1'b1;
          2'b01:   credit_q <= credit_q - 1'b1;
          default: credit_q <= credit_q;
        endcase
        // One nonzero per cycle while a descriptor is at the head
        if (issue) begin
          h_addr_q <= h_addr_q + 1'b1;
          if (last) begin
            ent_cnt_q   <= '0;
            rows_done_q <= rows_done_q + 1'b1;
          end else begin
            ent_cnt_q <= ent_cnt_q + 1'b1;
          end
        end
      end
    end
  end

  // ====================
  // Element output
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      vld_q  <= issue;
      last_q <= issue && last;
    end
  end

  always_ff @(posedge clk) begin
    num_node_q <= head.num_node;
    src_flag_q <= head.src_flag;
  end

  // Entry comes straight from memory, one cycle after its address
  always_comb begin
    elem_o.val      = h_dout_i.val;
    elem_o.col_idx  = h_dout_i.col_idx;
    elem_o.vld      = vld_q;
    elem_o.last     = last_q;
    elem_o.num_node = num_node_q;
    elem_o.src_flag = src_flag_q;
  end

endmodule

`default_nettype wire

// ==== sparse_pe.sv ====
// Expects the weight one cycle after wgt_addr_o; result is valid two cycles after a last entry
`default_nettype none
`timescale 1ns/1ps

module sparse_pe (
  input  logic               clk,
  input  logic               rst_n,
  input  spmm_pkg::pe_elem_t elem_i,
  output spmm_pkg::col_idx_t wgt_addr_o,
  input  spmm_pkg::val_t     wgt_dout_i,
  output spmm_pkg::wh_elem_t res_o,
  output logic               res_vld_o
);
  import spmm_pkg::*;

  // Stage 1 holds the element while the weight is read
  val_t                     val_q;
  logic                     vld_q;
  logic                     last_q;

  // Stage 2 multiply-accumulate
  logic signed [PROD_W-1:0] prod;
  wh_elem_t                 acc_base;
  wh_elem_t                 acc_q;

  // Column index doubles as the weight row
  assign wgt_addr_o = elem_i.col_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      vld_q  <= elem_i.vld;
      last_q <= elem_i.vld && elem_i.last;
    end
  end

  always_ff @(posedge clk) begin
    val_q <= elem_i.val;
  end

  // ====================
  // Accumulate
  // ====================
  assign prod = val_q * wgt_dout_i;

  // Start from zero once the previous row has been emitted
  assign acc_base = res_vld_o ? '0 : acc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q     <= '0;
      res_vld_o <= 1'b0;
    end else begin
      if (vld_q) begin
        acc_q <= acc_base + prod;
      end else begin
        acc_q <= acc_base;
      end
      res_vld_o <= vld_q && last_q;
    end
  end

  assign res_o = acc_q;

endmodule

`default_nettype wire

// ==== spmm_checker.sv ====
// Bound to spmm_top; last_mask_i marks each row's last H address and must be set before reset ends
`default_nettype none
`timescale 1ns/1ps

module spmm_checker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start_i,
  input  spmm_pkg::h_addr_t              h_addr_i,
  input  logic                           wh_we_i,
  input  spmm_pkg::wh_addr_t             wh_addr_i,
  input  logic                           done_i,
  input  logic [spmm_pkg::H_DEPTH-1:0]   last_mask_i
);
  import spmm_pkg::*;

  int                   fail_cnt = 0;
  logic [ROW_CNT_W-1:0] wr_cnt_q;
  h_addr_t              h_addr_q;
  logic                 last_issued;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt_q <= '0;
      h_addr_q <= '0;
    end else begin
      h_addr_q <= h_addr_i;
      if (!start_i) begin
        wr_cnt_q <= '0;
      end else if (wh_we_i) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  // H address only moves once the held entry has been issued
  assign last_issued = start_i && (h_addr_i != h_addr_q) && last_mask_i[h_addr_q];

  // ====================
  // Reset behavior
  // ====================
  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !wh_we_i && !done_i)
    else begin
      fail_cnt++;
      $error("write or done active during reset");
    end

  a_reset_exit: assert property (@(posedge clk) $rose(rst_n) |-> !wh_we_i && !done_i)
    else begin
      fail_cnt++;
      $error("write or done active right after reset");
    end

  // ====================
  // Write order and count
  // ====================
  a_wr_order: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_i |-> (wr_cnt_q < NUM_ROWS) && (wh_addr_i == wh_addr_t'(wr_cnt_q)))
    else begin
      fail_cnt++;
      $error("WH write address out of order");
    end

  a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
    (wh_we_i && wr_cnt_q == ROW_CNT_W'(NUM_ROWS - 1)) |=> done_i)
    else begin
      fail_cnt++;
      $error("done did not follow the last write");
    end

  a_done_count: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done_i) |-> $past(wh_we_i) && (wr_cnt_q == ROW_CNT_W'(NUM_ROWS)))
    else begin
      fail_cnt++;
      $error("done rose without all rows written");
    end

  a_no_wr_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> !wh_we_i)
    else begin
      fail_cnt++;
      $error("WH write after done");
    end

  // ====================
  // Row latency
  // ====================
  a_last_to_write: assert property (@(posedge clk) disable iff (!rst_n)
    last_issued |-> ##2 wh_we_i)
    else begin
      fail_cnt++;
      $error("no write 3 cycles after a row's last entry");
    end

  a_write_from_last: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_i |-> $past(last_issued, 2))
    else begin
      fail_cnt++;
      $error("write not preceded by a row's last entry");
    end

endmodule

`default_nettype wire

// ==== spmm_pkg.sv ====
// Sizes are fixed at 16 input features, 4 output features and 8 rows. Zero-length rows unsupported
`default_nettype none

package spmm_pkg;

  // ====================
  // Sizes
  // ====================
  localparam int DATA_W          = 8;
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int NUM_ROWS        = 8;
  localparam int H_DEPTH         = 64;
  localparam int FIFO_DEPTH      = 4;
  // Full product plus growth over a whole row
  localparam int WH_ELEM_W       = 2 * DATA_W + $clog2(NUM_FEATURE_IN);

  // Derived field widths
  localparam int PROD_W      = 2 * DATA_W;
  localparam int COL_IDX_W   = $clog2(NUM_FEATURE_IN);
  localparam int ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1);
  localparam int NUM_NODE_W  = 8;
  localparam int H_ADDR_W    = $clog2(H_DEPTH);
  localparam int NODE_ADDR_W = $clog2(NUM_ROWS);
  localparam int WH_ADDR_W   = $clog2(NUM_ROWS);
  localparam int ROW_CNT_W   = $clog2(NUM_ROWS + 1);
  localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

  // ====================
  // Vector types
  // ====================
  typedef logic signed [DATA_W-1:0]    val_t;
  typedef logic [COL_IDX_W-1:0]        col_idx_t;
  typedef logic [ROW_LEN_W-1:0]        row_len_t;
  typedef logic [NUM_NODE_W-1:0]       num_node_t;
  typedef logic [H_ADDR_W-1:0]         h_addr_t;
  typedef logic [NODE_ADDR_W-1:0]      node_addr_t;
  typedef logic [WH_ADDR_W-1:0]        wh_addr_t;
  typedef logic signed [WH_ELEM_W-1:0] wh_elem_t;

  // ====================
  // Structs
  // ====================
  // One nonzero of H as stored in memory
  typedef struct packed {
    col_idx_t col_idx;
    val_t     val;
  } h_entry_t;

  // Per-row descriptor
  typedef struct packed {
    row_len_t  row_len;
    num_node_t num_node;
    logic      src_flag;
  } node_info_t;

  // Streamed nonzero broadcast to every PE
  typedef struct packed {
    val_t      val;
    col_idx_t  col_idx;
    logic      vld;
    logic      last;
    num_node_t num_node;
    logic      src_flag;
  } pe_elem_t;

  typedef struct packed {
    wh_elem_t [NUM_FEATURE_OUT-1:0] elem;
    num_node_t                      num_node;
    logic                           src_flag;
  } wh_word_t;

endpackage

`default_nettype wire

// ==== spmm_top.f ====
spmm_pkg.sv
node_info_fifo.sv
row_sequencer.sv
sparse_pe.sv
wh_writer.sv
spmm_top.sv
spmm_checker.sv
tb_spmm.sv

// ==== spmm_top.sv ====
// All memories must return data one cycle after the address; the WH port never stalls
`default_nettype none
`timescale 1ns/1ps

module spmm_top (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               start_i,
  // H data memory
  output spmm_pkg::h_addr_t                                  h_addr_o,
  input  spmm_pkg::h_entry_t                                 h_dout_i,
  // Node-info memory
  output spmm_pkg::node_addr_t                               node_addr_o,
  input  spmm_pkg::node_info_t                               node_dout_i,
  // One weight port per output column
  output spmm_pkg::col_idx_t [spmm_pkg::NUM_FEATURE_OUT-1:0] wgt_addr_o,
  input  spmm_pkg::val_t [spmm_pkg::NUM_FEATURE_OUT-1:0]     wgt_dout_i,
  // WH result port
  output logic                                               wh_we_o,
  output spmm_pkg::wh_addr_t                                 wh_addr_o,
  output spmm_pkg::wh_word_t                                 wh_data_o,
  output logic                                               done_o
);
  import spmm_pkg::*;

  pe_elem_t                       elem;
  wh_elem_t [NUM_FEATURE_OUT-1:0] pe_res;
  logic [NUM_FEATURE_OUT-1:0]     pe_res_vld;

  row_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .node_addr_o (node_addr_o),
    .node_dout_i (node_dout_i),
    .h_addr_o    (h_addr_o),
    .h_dout_i    (h_dout_i),
    .elem_o      (elem)
  );

  // ====================
  // PE bank
  // ====================
  for (genvar g = 0; g < NUM_FEATURE_OUT; g++) begin : g_pe
    sparse_pe u_pe (
      .clk        (clk),
      .rst_n      (rst_n),
      .elem_i     (elem),
      .wgt_addr_o (wgt_addr_o[g]),
      .wgt_dout_i (wgt_dout_i[g]),
      .res_o      (pe_res[g]),
      .res_vld_o  (pe_res_vld[g])
    );
  end

  // PEs run in lockstep so PE 0 speaks for the bank
  wh_writer u_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (start_i),
    .elem_i    (elem),
    .res_i     (pe_res),
    .res_vld_i (pe_res_vld[0]),
    .wh_we_o   (wh_we_o),
    .wh_addr_o (wh_addr_o),
    .wh_data_o (wh_data_o),
    .done_o    (done_o)
  );

endmodule

`default_nettype wire

// ==== tb_spmm.sv ====
// Single run of NUM_ROWS rows from random memories; row lengths 1 to 8 keep H within 64 entries
`default_nettype none
`timescale 1ns/1ps

module tb_spmm;
  import spmm_pkg::*;

  localparam int TIMEOUT_CYCLES = 4 * (NUM_ROWS * 8 + 20);

  logic                            clk;
  logic                            rst_n;
  logic                            start_i;
  h_addr_t                         h_addr;
  h_entry_t                        h_dout;
  node_addr_t                      node_addr;
  node_info_t                      node_dout;
  col_idx_t [NUM_FEATURE_OUT-1:0]  wgt_addr;
  val_t [NUM_FEATURE_OUT-1:0]      wgt_dout;
  logic                            wh_we;
  wh_addr_t                        wh_addr;
  wh_word_t                        wh_data;
  logic                            done;

  // Memory contents and reference data
  h_entry_t             h_mem [H_DEPTH];
  node_info_t           node_mem [NUM_ROWS];
  int                   h_col [H_DEPTH];
  int                   h_val [H_DEPTH];
  int                   w_val [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  int                   row_start [NUM_ROWS];
  int                   row_len [NUM_ROWS];
  int                   exp_res [NUM_ROWS][NUM_FEATURE_OUT];
  logic [H_DEPTH-1:0]   last_mask;

  integer               seed;
  int                   check_errs;
  int                   wr_idx;
  int                   cycle_cnt;

  spmm_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .h_addr_o    (h_addr),
    .h_dout_i    (h_dout),
    .node_addr_o (node_addr),
    .node_dout_i (node_dout),
    .wgt_addr_o  (wgt_addr),
    .wgt_dout_i  (wgt_dout),
    .wh_we_o     (wh_we),
    .wh_addr_o   (wh_addr),
    .wh_data_o   (wh_data),
    .done_o      (done)
  );

  bind spmm_top spmm_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .h_addr_i    (h_addr_o),
    .wh_we_i     (wh_we_o),
    .wh_addr_i   (wh_addr_o),
    .done_i      (done_o),
    .last_mask_i (tb_spmm.last_mask)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ====================
  // Memory models
  // ====================
  // Every read returns one cycle after its address
  always @(posedge clk) begin
    h_dout    <= h_mem[h_addr];
    node_dout <= node_mem[node_addr];
    for (int g = 0; g < NUM_FEATURE_OUT; g++) begin
      wgt_dout[g] <= val_t'(w_val[wgt_addr[g]][g]);
    end
  end

  task automatic build_memories();
    int  addr;
    int  len;
    byte b;
    addr = 0;
    last_mask = '0;
    for (int a = 0; a < H_DEPTH; a++) begin
      h_col[a] = $unsigned($random(seed)) % NUM_FEATURE_IN;
      b = byte'($random(seed));
      h_val[a] = b;
      h_mem[a].col_idx = col_idx_t'(h_col[a]);
      h_mem[a].val     = val_t'(h_val[a]);
    end
    for (int k = 0; k < NUM_FEATURE_IN; k++) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        b = byte'($random(seed));
        w_val[k][c] = b;
      end
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      len = 1 + ($unsigned($random(seed)) % 8);
      // Two short rows back to back at the start
      if (r < 2) begin
        len = 1;
      end
      row_start[r] = addr;
      row_len[r]   = len;
      node_mem[r].row_len  = row_len_t'(len);
      node_mem[r].num_node = num_node_t'($random(seed));
      node_mem[r].src_flag = 1'($random(seed));
      addr = addr + len;
      last_mask[addr - 1] = 1'b1;
    end
  endtask

  // Software reference for each WH row
  task automatic compute_expected();
    int a;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        exp_res[r][c] = 0;
        for (int k = 0; k < row_len[r]; k++) begin
          a = row_start[r] + k;
          exp_res[r][c] = exp_res[r][c] + h_val[a] * w_val[h_col[a]][c];
        end
      end
    end
  endtask

  task automatic check_row(input int r);
    int got;
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      got = int'(wh_data.elem[c]);
      assert (got == exp_res[r][c]) else begin
        check_errs++;
        $display("ERROR at %0t ns: row %0d col %0d expected %0d got %0d",
                 $time, r, c, exp_res[r][c], got);
      end
    end
    assert (wh_data.num_node == node_mem[r].num_node) else begin
      check_errs++;
      $display("ERROR at %0t ns: row %0d num_node expected %0d got %0d",
               $time, r, node_mem[r].num_node, wh_data.num_node);
    end
    assert (wh_data.src_flag == node_mem[r].src_flag) else begin
      check_errs++;
      $display("ERROR at %0t ns: row %0d src_flag expected %0b got %0b",
               $time, r, node_mem[r].src_flag, wh_data.src_flag);
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst_n && wh_we) begin
      if (wr_idx < NUM_ROWS) begin
        check_row(wr_idx);
      end else begin
        check_errs++;
        $display("Unexpected extra WH write at %0t ns", $time);
      end
      wr_idx++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing", cycle_cnt);
      $display("Done: errors found");
      $finish;
    end
  end

  // ====================
  // Stimulus
  // ====================
  initial begin
    rst_n      = 1'b0;
    start_i    = 1'b0;
    h_dout     = '0;
    node_dout  = '0;
    wgt_dout   = '0;
    seed       = 32'hbea2;
    check_errs = 0;
    wr_idx     = 0;
    cycle_cnt  = 0;
    build_memories();
    compute_expected();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    start_i <= 1'b1;
    do begin
      @(negedge clk);
    end while (!done);
    @(posedge clk);
    start_i <= 1'b0;
    repeat (3) @(negedge clk);
    assert (!done) else begin
      check_errs++;
      $display("done_o stayed high after start_i fell");
    end
    assert (wr_idx == NUM_ROWS) else begin
      check_errs++;
      $display("Saw %0d WH writes instead of %0d", wr_idx, NUM_ROWS);
    end
    $display("Check errors: %0d, assertion failures: %0d",
             check_errs, UUT.u_checker.fail_cnt);
    if (check_errs == 0 && UUT.u_checker.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wh_writer.sv ====
// Assumes all PEs share one timing; done_o holds until start_i falls, which also rewinds the address
`default_nettype none
`timescale 1ns/1ps

module wh_writer (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               start_i,
  input  spmm_pkg::pe_elem_t                                 elem_i,
  input  spmm_pkg::wh_elem_t [spmm_pkg::NUM_FEATURE_OUT-1:0] res_i,
  input  logic                                               res_vld_i,
  output logic                                               wh_we_o,
  output spmm_pkg::wh_addr_t                                 wh_addr_o,
  output spmm_pkg::wh_word_t                                 wh_data_o,
  output logic                                               done_o
);
  import spmm_pkg::*;

  // Tag pipeline two stages deep to match the PE
  num_node_t num_node_q1;
  num_node_t num_node_q2;
  logic      src_flag_q1;
  logic      src_flag_q2;
  wh_addr_t  wh_addr_q;

  always_ff @(posedge clk) begin
    num_node_q1 <= elem_i.num_node;
    src_flag_q1 <= elem_i.src_flag;
    num_node_q2 <= num_node_q1;
    src_flag_q2 <= src_flag_q1;
  end

  // Strobe and results come from the PE accumulate registers
  assign wh_we_o = res_vld_i;

  always_comb begin
    wh_data_o.elem     = res_i;
    wh_data_o.num_node = num_node_q2;
    wh_data_o.src_flag = src_flag_q2;
  end

  // Address doubles as the count of rows written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_addr_q <= '0;
      done_o    <= 1'b0;
    end else if (!start_i) begin
      wh_addr_q <= '0;
      done_o    <= 1'b0;
    end else if (wh_we_o) begin
      wh_addr_q <= wh_addr_q + 1'b1;
      if (wh_addr_q == WH_ADDR_W'(NUM_ROWS - 1)) begin
        done_o <= 1'b1;
      end
    end
  end

  assign wh_addr_o = wh_addr_q;

endmodule

`default_nettype wire
